// File: logic/condition_unit.sv
//----------------------------------------------------------------------
// Flag condition select, invert and execute decision
//----------------------------------------------------------------------

`timescale 1ns/100ps

module condition_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             instr_valid,
    input  ctrl_pkg::instr_t instr,
    input  ctrl_pkg::flags_t flags,        // Low means flag set
    input  logic             flag_di_n,
    input  logic             flag_do_n,
    output logic             do_exec
);
    import ctrl_pkg::*;

    cond_t       cond;
    logic        invert;
    logic [15:0] cond_vec_n;                 // Low entry means condition met
    logic        cond_met;

    assign cond   = {instr[COND_HI_BIT], instr[COND_LO_MSB:COND_LO_LSB]};
    assign invert = instr[INVERT_BIT];

    //------------------------------------------------------------------
    // Sixteen inputs of the condition mux
    always_comb begin
        cond_vec_n                = '0;      // Grounded codes count as met
        cond_vec_n[COND_ALWAYS]   = 1'b0;
        cond_vec_n[COND_CARRY]    = flags[FLAG_CARRY];
        cond_vec_n[COND_ZERO]     = flags[FLAG_ZERO];
        cond_vec_n[COND_OVERFLOW] = flags[FLAG_OVERFLOW];
        cond_vec_n[COND_NEGATIVE] = flags[FLAG_NEGATIVE];
        cond_vec_n[COND_GT]       = flags[FLAG_GT];
        cond_vec_n[COND_LT]       = flags[FLAG_LT];
        cond_vec_n[COND_EQ]       = flags[FLAG_EQ];
        cond_vec_n[COND_NE]       = flags[FLAG_NE];
        cond_vec_n[COND_DI]       = flag_di_n;   // Input data ready
        cond_vec_n[COND_DO]       = flag_do_n;   // Output port ready
    end

    assign cond_met = ~cond_vec_n[cond];

    // Invert turns "if DO" into "if not DO"
    assign do_exec = cond_met ^ invert;

    //------------------------------------------------------------------
    // A valid word with clean flags must give a clean decision
    a_exec_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid |-> !$isunknown(do_exec)
    );

endmodule

// File: logic/control_combiner.sv
//----------------------------------------------------------------------
// Execute gating of target and flag update, output registers
//----------------------------------------------------------------------

`timescale 1ns/100ps

module control_combiner (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  logic              do_exec,
    decode_if.consumer        dec,
    output ctrl_pkg::alu_op_t alu_op,
    output ctrl_pkg::sel8_t   adev_sel,
    output ctrl_pkg::sel16_t  bdev_sel,
    output ctrl_pkg::sel16_t  tdev_sel,
    output logic              set_flags_n,
    output logic              addrmode_register_n,
    output logic              bbus_en,
    output logic [7:0]        bbus_out,
    output logic              address_en,
    output logic [15:0]       address_out,
    output logic              out_valid
);
    import ctrl_pkg::*;

    logic bdev_immed;                        // ROM immediate drives B bus

    assign bdev_immed = ~dec.bdev_sel[BDEV_IMMED];

    //------------------------------------------------------------------
    // Control outputs, inactive in reset and while no valid word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            adev_sel            <= '1;
            bdev_sel            <= '1;
            tdev_sel            <= '1;
            set_flags_n         <= 1'b1;
            addrmode_register_n <= 1'b1;
            bbus_en             <= 1'b0;
            address_en          <= 1'b0;
            out_valid           <= 1'b0;
        end else if (!instr_valid) begin
            adev_sel            <= '1;       // Nothing drives either bus
            bdev_sel            <= '1;
            tdev_sel            <= '1;
            set_flags_n         <= 1'b1;
            addrmode_register_n <= 1'b1;
            bbus_en             <= 1'b0;
            address_en          <= 1'b0;
            out_valid           <= 1'b0;
        end else begin
            adev_sel            <= dec.adev_sel;
            bdev_sel            <= dec.bdev_sel;
            tdev_sel            <= do_exec ? dec.tdev_sel : '1;   // Skipped write
            set_flags_n         <= ~(dec.set_flags_bit & do_exec);
            addrmode_register_n <= dec.amode_bit;   // Low means register mode
            address_en          <= dec.amode_bit;   // Direct address onto bus
            bbus_en             <= bdev_immed;
            out_valid           <= 1'b1;
        end
    end

    // Values that travel with their enables
    always_ff @(posedge clk) begin
        alu_op      <= dec.alu_op;
        bbus_out    <= dec.immed;
        address_out <= dec.direct_address;
    end

    //------------------------------------------------------------------
    // A failed condition never reaches a target device
    a_no_write_when_skipped: assert property (
        @(posedge clk) disable iff (!rst_n)
        !do_exec |=> (tdev_sel == '1)
    );

endmodule

// File: logic/controller_top.sv
//----------------------------------------------------------------------
// Control unit top, ROM through registered control outputs
//----------------------------------------------------------------------

`timescale 1ns/100ps

module controller_top (
    input  logic                clk,
    input  logic                rst_n,
    input  ctrl_pkg::rom_addr_t pc,
    input  ctrl_pkg::flags_t    flags,
    input  logic                flag_di_n,
    input  logic                flag_do_n,
    output ctrl_pkg::alu_op_t   alu_op,
    output ctrl_pkg::sel8_t     adev_sel,
    output ctrl_pkg::sel16_t    bdev_sel,
    output ctrl_pkg::sel16_t    tdev_sel,
    output logic                set_flags_n,
    output logic                addrmode_register_n,
    output logic                bbus_en,
    output logic [7:0]          bbus_out,
    output logic                address_en,
    output logic [15:0]         address_out,
    output logic                out_valid
);
    import ctrl_pkg::*;

    instr_t instr;                           // Stage 1 word
    logic   instr_valid;
    logic   do_exec;

    decode_if dec_bus ();

    instr_rom u_rom (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (pc),
        .instr       (instr),
        .instr_valid (instr_valid)
    );

    condition_unit u_cond (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flags       (flags),
        .flag_di_n   (flag_di_n),
        .flag_do_n   (flag_do_n),
        .do_exec     (do_exec)
    );

    field_decoder u_dec (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec         (dec_bus.producer)
    );

    // Stage 2 registers
    control_combiner u_comb (
        .clk                 (clk),
        .rst_n               (rst_n),
        .instr_valid         (instr_valid),
        .do_exec             (do_exec),
        .dec                 (dec_bus.consumer),
        .alu_op              (alu_op),
        .adev_sel            (adev_sel),
        .bdev_sel            (bdev_sel),
        .tdev_sel            (tdev_sel),
        .set_flags_n         (set_flags_n),
        .addrmode_register_n (addrmode_register_n),
        .bbus_en             (bbus_en),
        .bbus_out            (bbus_out),
        .address_en          (address_en),
        .address_out         (address_out),
        .out_valid           (out_valid)
    );

endmodule

// File: logic/ctrl_pkg.sv
//----------------------------------------------------------------------
// Shared widths, typedefs, instruction field positions, flag bit
// positions, condition codes and device numbers of the control unit
//----------------------------------------------------------------------

package ctrl_pkg;

    localparam int    ROM_AWIDTH    = 8;                 // 256-word program store
    localparam int    ROM_DEPTH     = 1 << ROM_AWIDTH;
    localparam int    INSTR_WIDTH   = 48;                // Six ROM bytes side by side
    localparam string ROM_INIT_FILE = "program.hex";

    typedef logic [ROM_AWIDTH-1:0]  rom_addr_t;
    typedef logic [INSTR_WIDTH-1:0] instr_t;
    typedef logic [4:0]             alu_op_t;
    typedef logic [2:0]             adev_t;
    typedef logic [3:0]             bdev_t;
    typedef logic [3:0]             tdev_t;
    typedef logic [3:0]             cond_t;
    typedef logic [7:0]             flags_t;             // Active low, czonGLEN
    typedef logic [7:0]             sel8_t;              // Active-low one-hot
    typedef logic [15:0]            sel16_t;             // Active-low one-hot

    //------------------------------------------------------------------
    // Instruction field positions
    localparam int IMMED_LSB     = 0;                    // Byte 1
    localparam int IMMED_MSB     = 7;
    localparam int DADDR_LSB     = 8;                    // Bytes 2 and 3
    localparam int DADDR_MSB     = 23;
    localparam int AMODE_BIT     = 24;
    localparam int BDEV_HI_BIT   = 26;                   // Bit 25 spare
    localparam int INVERT_BIT    = 27;
    localparam int SET_FLAGS_BIT = 28;
    localparam int COND_LO_LSB   = 29;
    localparam int COND_LO_MSB   = 31;
    localparam int COND_HI_BIT   = 32;
    localparam int BDEV_LO_LSB   = 33;
    localparam int BDEV_LO_MSB   = 35;
    localparam int ADEV_LSB      = 36;
    localparam int ADEV_MSB      = 38;
    localparam int TDEV_LSB      = 39;                   // Low bit sits in byte 5
    localparam int TDEV_MSB      = 42;
    localparam int ALU_OP_LSB    = 43;
    localparam int ALU_OP_MSB    = 47;

    // Flag positions inside flags_t, top bit down
    localparam int FLAG_CARRY    = 7;
    localparam int FLAG_ZERO     = 6;
    localparam int FLAG_OVERFLOW = 5;
    localparam int FLAG_NEGATIVE = 4;
    localparam int FLAG_GT       = 3;
    localparam int FLAG_LT       = 2;
    localparam int FLAG_EQ       = 1;
    localparam int FLAG_NE       = 0;

    //------------------------------------------------------------------
    // Condition codes, 11 to 15 are grounded inputs
    localparam cond_t COND_ALWAYS   = 4'd0;
    localparam cond_t COND_CARRY    = 4'd1;
    localparam cond_t COND_ZERO     = 4'd2;
    localparam cond_t COND_OVERFLOW = 4'd3;
    localparam cond_t COND_NEGATIVE = 4'd4;
    localparam cond_t COND_GT       = 4'd5;
    localparam cond_t COND_LT       = 4'd6;
    localparam cond_t COND_EQ       = 4'd7;
    localparam cond_t COND_NE       = 4'd8;
    localparam cond_t COND_DI       = 4'd9;
    localparam cond_t COND_DO       = 4'd10;

    localparam bdev_t BDEV_IMMED    = 4'd15;             // ROM immediate onto B bus

endpackage

// File: logic/decode_if.sv
//----------------------------------------------------------------------
// Decoded instruction fields, field decoder to control combiner
//----------------------------------------------------------------------

`timescale 1ns/100ps

interface decode_if;
    import ctrl_pkg::*;

    sel8_t       adev_sel;                   // A bus source, active low
    sel16_t      bdev_sel;                   // B bus source, active low
    sel16_t      tdev_sel;                   // Target, not yet gated by do_exec
    logic        set_flags_bit;              // Active high in the word
    logic        amode_bit;                  // High selects direct addressing
    logic [7:0]  immed;
    logic [15:0] direct_address;
    alu_op_t     alu_op;

    // Decoder side
    modport producer (
        output adev_sel, bdev_sel, tdev_sel, set_flags_bit,
        output amode_bit, immed, direct_address, alu_op
    );

    // Combiner side
    modport consumer (
        input adev_sel, bdev_sel, tdev_sel, set_flags_bit,
        input amode_bit, immed, direct_address, alu_op
    );

endinterface

// File: logic/field_decoder.sv
//----------------------------------------------------------------------
// Instruction field split and active-low device select decoders
//----------------------------------------------------------------------

`timescale 1ns/100ps

module field_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  ctrl_pkg::instr_t instr,
    input  logic             instr_valid,
    decode_if.producer       dec
);
    import ctrl_pkg::*;

    adev_t  adev;
    bdev_t  bdev;
    tdev_t  tdev;

    // One low bit at the device number, like a 74138 pair
    function automatic sel16_t dev_decode(input logic [3:0] num);
        return ~(sel16_t'(1) << num);
    endfunction

    //------------------------------------------------------------------
    // Field split
    assign adev = instr[ADEV_MSB:ADEV_LSB];
    assign bdev = {instr[BDEV_HI_BIT], instr[BDEV_LO_MSB:BDEV_LO_LSB]};  // Split field
    assign tdev = instr[TDEV_MSB:TDEV_LSB];

    assign dec.alu_op         = instr[ALU_OP_MSB:ALU_OP_LSB];
    assign dec.immed          = instr[IMMED_MSB:IMMED_LSB];
    assign dec.direct_address = instr[DADDR_MSB:DADDR_LSB];
    assign dec.amode_bit      = instr[AMODE_BIT];
    assign dec.set_flags_bit  = instr[SET_FLAGS_BIT];

    //------------------------------------------------------------------
    // Device select decoders
    assign dec.adev_sel = ~(sel8_t'(1) << adev);   // Single 3-to-8
    assign dec.bdev_sel = dev_decode(bdev);  // Two 3-to-8 halves on bdev[3]
    assign dec.tdev_sel = dev_decode(tdev);  // Gated later by do_exec

    //------------------------------------------------------------------
    // Exactly one device selected per bus
    a_adev_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid |-> $onehot(~dec.adev_sel)
    );

    a_bdev_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid |-> $onehot(~dec.bdev_sel)
    );

    a_tdev_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        instr_valid |-> $onehot(~dec.tdev_sel)
    );

endmodule

// File: logic/instr_rom.sv
//----------------------------------------------------------------------
// Program ROM, registered read with a valid bit
//----------------------------------------------------------------------

`timescale 1ns/100ps

module instr_rom (
    input  logic               clk,
    input  logic               rst_n,
    input  ctrl_pkg::rom_addr_t pc,
    output ctrl_pkg::instr_t    instr,
    output logic               instr_valid
);
    import ctrl_pkg::*;

    instr_t mem [ROM_DEPTH];                 // Six byte-wide ROMs as one word

    // Unprogrammed words read as all zeros
    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            mem[i] = '0;
        end
        $readmemh(ROM_INIT_FILE, mem);
    end

    // Word lands one edge after pc
    always_ff @(posedge clk) begin
        instr <= mem[pc];
    end

    // First word after reset is valid
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b1;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module controller_tb \
    -o controller_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

# The ROM loads program.hex from the working directory
cp tests/program.hex program.hex
if [ $? -ne 0 ]; then
    echo "Could not copy the program image"
    exit 1
fi

./obj_dir/controller_sim > "$LOG" 2>&1
status=$?
rm -f program.hex
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    echo "Simulation result: passed"
    exit 0
fi
echo "Simulation result: failed"
exit 1

// File: sources.f
logic/ctrl_pkg.sv
logic/decode_if.sv
logic/instr_rom.sv
logic/condition_unit.sv
logic/field_decoder.sv
logic/control_combiner.sv
logic/controller_top.sv
tests/controller_tb.sv

// File: tests/controller_tb.sv
//----------------------------------------------------------------------
// Directed testbench for the control unit, with a reference model of
// the field decode and flag condition rules
//----------------------------------------------------------------------

`timescale 1ns/100ps

module controller_tb;
    import ctrl_pkg::*;

    localparam int PROG_WORDS  = 16;         // Programmed part of the ROM
    localparam int COND_ROUNDS = 3;          // Random flag sets per word
    localparam int B2B_LEN     = 24;
    localparam int MAX_CYCLES  = 400;        // Tests need about 320 cycles

    logic        clk;
    logic        rst_n;
    rom_addr_t   pc;
    flags_t      flags;
    logic        flag_di_n;
    logic        flag_do_n;
    alu_op_t     alu_op;
    sel8_t       adev_sel;
    sel16_t      bdev_sel;
    sel16_t      tdev_sel;
    logic        set_flags_n;
    logic        addrmode_register_n;
    logic        bbus_en;
    logic [7:0]  bbus_out;
    logic        address_en;
    logic [15:0] address_out;
    logic        out_valid;

    instr_t rom_image [ROM_DEPTH];           // Testbench copy of the program
    int     errors       = 0;
    int     checks       = 0;
    int     tests_run    = 0;
    int     tests_failed = 0;
    int     cycle_count  = 0;

    controller_top i_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .pc                  (pc),
        .flags               (flags),
        .flag_di_n           (flag_di_n),
        .flag_do_n           (flag_do_n),
        .alu_op              (alu_op),
        .adev_sel            (adev_sel),
        .bdev_sel            (bdev_sel),
        .tdev_sel            (tdev_sel),
        .set_flags_n         (set_flags_n),
        .addrmode_register_n (addrmode_register_n),
        .bbus_en             (bbus_en),
        .bbus_out            (bbus_out),
        .address_en          (address_en),
        .address_out         (address_out),
        .out_valid           (out_valid)
    );

    always #50 clk = ~clk;                   // 100 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, tests did not finish", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    //------------------------------------------------------------------
    // Reference model
    function automatic sel8_t low_select8(input int num);
        sel8_t s;
        s = '1;
        for (int k = 7; k >= 0; k--) begin
            s = {s[6:0], logic'(k != num)};  // Top bit shifted in first
        end
        return s;
    endfunction

    function automatic sel16_t low_select16(input int num);
        sel16_t s;
        s = '1;
        for (int k = 15; k >= 0; k--) begin
            s = {s[14:0], logic'(k != num)};
        end
        return s;
    endfunction

    function automatic int bdev_of(input instr_t w);
        return int'({w[BDEV_HI_BIT], w[BDEV_LO_MSB:BDEV_LO_LSB]});   // Split field
    endfunction

    function automatic logic exec_expected(input instr_t w, input flags_t f,
                                           input logic di_n, input logic do_n);
        cond_t code;
        logic  met;
        code = {w[COND_HI_BIT], w[COND_LO_MSB:COND_LO_LSB]};
        case (code)                          // A flag is set when low
            COND_CARRY:    met = !f[7];
            COND_ZERO:     met = !f[6];
            COND_OVERFLOW: met = !f[5];
            COND_NEGATIVE: met = !f[4];
            COND_GT:       met = !f[3];
            COND_LT:       met = !f[2];
            COND_EQ:       met = !f[1];
            COND_NE:       met = !f[0];
            COND_DI:       met = !di_n;
            COND_DO:       met = !do_n;
            default:       met = 1'b1;       // Always, and grounded 11 to 15
        endcase
        return met ^ w[INVERT_BIT];
    endfunction

    //------------------------------------------------------------------
    // Compare tasks, one per kind of result
    task automatic compare_sel8(input string name, input sel8_t got, input sel8_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_sel16(input string name, input sel16_t got, input sel16_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_alu_op(input string name, input alu_op_t got, input alu_op_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    //------------------------------------------------------------------
    // Output groups checked against one ROM word
    task automatic check_inactive();
        compare_sel8("adev_sel", adev_sel, '1);
        compare_sel16("bdev_sel", bdev_sel, '1);
        compare_sel16("tdev_sel", tdev_sel, '1);
        compare_bit("set_flags_n", set_flags_n, 1'b1);
        compare_bit("addrmode_register_n", addrmode_register_n, 1'b1);
        compare_bit("bbus_en", bbus_en, 1'b0);
        compare_bit("address_en", address_en, 1'b0);
        compare_bit("out_valid", out_valid, 1'b0);
    endtask

    task automatic check_fields(input instr_t w);
        compare_bit("out_valid", out_valid, 1'b1);
        compare_alu_op("alu_op", alu_op, w[ALU_OP_MSB:ALU_OP_LSB]);
        compare_sel8("adev_sel", adev_sel, low_select8(int'(w[ADEV_MSB:ADEV_LSB])));
        compare_sel16("bdev_sel", bdev_sel, low_select16(bdev_of(w)));
    endtask

    task automatic check_target(input instr_t w, input flags_t f, input logic di_n,
                                input logic do_n);
        sel16_t exp;
        exp = low_select16(int'(w[TDEV_MSB:TDEV_LSB]));
        if (!exec_expected(w, f, di_n, do_n)) begin
            exp = '1;                        // Skipped, no target written
        end
        compare_sel16("tdev_sel", tdev_sel, exp);
    endtask

    task automatic check_flag_update(input instr_t w, input flags_t f, input logic di_n,
                                     input logic do_n);
        compare_bit("set_flags_n", set_flags_n,
                    !(w[SET_FLAGS_BIT] && exec_expected(w, f, di_n, do_n)));
    endtask

    task automatic check_addr_bus(input instr_t w);
        compare_bit("addrmode_register_n", addrmode_register_n, w[AMODE_BIT]);
        compare_bit("address_en", address_en, w[AMODE_BIT]);
        compare_addr("address_out", address_out, w[DADDR_MSB:DADDR_LSB]);
        compare_bit("bbus_en", bbus_en, logic'(bdev_of(w) == int'(BDEV_IMMED)));
        compare_byte("bbus_out", bbus_out, w[IMMED_MSB:IMMED_LSB]);
    endtask

    //------------------------------------------------------------------
    // Stimulus helpers
    task automatic random_flags(output flags_t f, output logic di_n, output logic do_n);
        logic [31:0] r;
        r    = $urandom();
        f    = r[7:0];
        di_n = r[8];
        do_n = r[9];
    endtask

    // Word lands in the ROM on the next edge, outputs one edge later
    task automatic present(input rom_addr_t addr, input flags_t f, input logic di_n,
                           input logic do_n);
        @(posedge clk);
        pc        <= addr;
        flags     <= f;
        flag_di_n <= di_n;
        flag_do_n <= do_n;
        repeat (2) @(posedge clk);
        @(negedge clk);                      // Registered outputs settled
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - err_before);
        end
    endtask

    //------------------------------------------------------------------
    // Tests
    task automatic test_reset_state();
        int e0;
        e0 = errors;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_inactive();
        @(posedge clk);
        rst_n <= 1'b1;                       // Third reset edge still sees it low
        @(negedge clk);
        check_inactive();
        @(posedge clk);
        @(negedge clk);
        check_inactive();                    // ROM word valid, not yet registered
        @(posedge clk);
        @(negedge clk);
        compare_bit("out_valid", out_valid, 1'b1);
        end_test("reset", e0);
    endtask

    task automatic test_field_decode();
        flags_t f;
        logic   di;
        logic   dn;
        int     e0;
        e0 = errors;
        for (int i = 0; i < PROG_WORDS; i++) begin
            random_flags(f, di, dn);
            present(rom_addr_t'(i), f, di, dn);
            check_fields(rom_image[i]);
        end
        end_test("field decode", e0);
    endtask

    task automatic test_conditions();
        flags_t f;
        logic   di;
        logic   dn;
        int     e0;
        e0 = errors;
        for (int r = 0; r < COND_ROUNDS; r++) begin
            for (int i = 0; i < PROG_WORDS; i++) begin   // Word i holds condition i
                random_flags(f, di, dn);
                present(rom_addr_t'(i), f, di, dn);
                check_target(rom_image[i], f, di, dn);
            end
        end
        end_test("conditions", e0);
    endtask

    task automatic test_set_flags();
        flags_t f;
        logic   di;
        logic   dn;
        int     e0;
        e0 = errors;
        for (int i = 0; i < PROG_WORDS; i++) begin
            random_flags(f, di, dn);
            present(rom_addr_t'(i), f, di, dn);
            check_flag_update(rom_image[i], f, di, dn);
        end
        end_test("set flags", e0);
    endtask

    task automatic test_address_immed();
        flags_t f;
        logic   di;
        logic   dn;
        int     e0;
        e0 = errors;
        for (int i = 0; i < PROG_WORDS; i++) begin
            random_flags(f, di, dn);
            present(rom_addr_t'(i), f, di, dn);
            check_addr_bus(rom_image[i]);
        end
        end_test("address and immediate", e0);
    endtask

    // New pc each edge, flags for a word follow it by one edge
    task automatic test_back_to_back();
        rom_addr_t seq_pc [B2B_LEN];
        flags_t    seq_f  [B2B_LEN];
        logic      seq_di [B2B_LEN];
        logic      seq_do [B2B_LEN];
        instr_t    w;
        int        e0;
        e0 = errors;
        for (int j = 0; j < B2B_LEN; j++) begin
            seq_pc[j] = rom_addr_t'($urandom_range(PROG_WORDS - 1, 0));
            random_flags(seq_f[j], seq_di[j], seq_do[j]);
        end
        for (int c = 0; c < B2B_LEN + 2; c++) begin
            @(posedge clk);
            if (c < B2B_LEN) begin
                pc <= seq_pc[c];
            end
            if (c >= 1 && c <= B2B_LEN) begin
                flags     <= seq_f[c-1];
                flag_di_n <= seq_di[c-1];
                flag_do_n <= seq_do[c-1];
            end
            @(negedge clk);
            if (c >= 2) begin                // Word c-2 is at the outputs
                w = rom_image[seq_pc[c-2]];
                check_fields(w);
                check_target(w, seq_f[c-2], seq_di[c-2], seq_do[c-2]);
                check_flag_update(w, seq_f[c-2], seq_di[c-2], seq_do[c-2]);
                check_addr_bus(w);
            end
        end
        end_test("back to back", e0);
    endtask

    //------------------------------------------------------------------
    // Main sequence
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        pc        = '0;
        flags     = '1;                      // No flag set
        flag_di_n = 1'b1;
        flag_do_n = 1'b1;
        void'($urandom(99336));
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom_image[i] = '0;               // Unprogrammed words read as zero
        end
        $readmemh("tests/program.hex", rom_image);

        test_reset_state();
        test_field_decode();
        test_conditions();
        test_set_flags();
        test_address_immed();
        test_back_to_back();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tests/program.hex
// One 48-bit word per line: alu_op, tdev, adev, bdev, cond, invert, set_flags, amode
// in the upper 6 digits, direct address (4 digits) and immediate (2 digits) below
078000000000
1F1E2812345A
36AC54FFFFFF
4E3A78800101
65C885ABCD3C
7D56A95555AA
94E4D50F0FC3
AC72F97E8199
C38104246810
DB1F2CC0DEA5
F2AD50BEEF7F
0A3B7C010080
21C981432166
3957AD9ABCE7
50E5D1DEAD11
6873FDF00D42
